// File: logic/afifo_pkg.sv
package afifo_pkg;

   // Word and storage geometry
   localparam int data_width = 8;
   localparam int fifo_depth = 16;
   localparam int addr_width = 4;

   // Address plus the wrap bit
   localparam int ptr_width  = addr_width + 1;

   // Flag thresholds in words
   localparam int af_thresh  = 12;  // Write side, at or above
   localparam int ae_thresh  = 4;   // Read side, at or below

   typedef logic [data_width-1:0] data_t;
   typedef logic [addr_width-1:0] addr_t;
   typedef logic [ptr_width-1:0]  ptr_t;
   typedef logic [ptr_width-1:0]  level_t;  // 0 to fifo_depth

   // Binary count to reflected Gray
   function automatic ptr_t bin2gray(input ptr_t bin);
      ptr_t gray;
      gray = bin ^ (bin >> 1);
      return gray;
   endfunction

   // Gray back to binary, MSB first
   function automatic ptr_t gray2bin(input ptr_t gray);
      ptr_t bin;
      bin[ptr_width-1] = gray[ptr_width-1];
      for (int i = ptr_width - 2; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

   // Gray full pattern: top two bits inverted
   function automatic ptr_t gray_full(input ptr_t gray);
      ptr_t pat;
      pat = {~gray[ptr_width-1:ptr_width-2], gray[ptr_width-3:0]};
      return pat;
   endfunction

endpackage

// File: logic/afifo_ram.sv
`timescale 1ns/1ps

module afifo_ram import afifo_pkg::*; (
   input  logic  wclk,
   input  logic  wen,
   input  addr_t waddr,
   input  data_t wdata,
   input  logic  rclk,
   input  logic  rrstn,
   input  logic  ren,
   input  addr_t raddr,
   output data_t rdata
);

   // Storage array
   data_t mem [fifo_depth];

   // Write port
   always_ff @(posedge wclk) begin
      if (wen) begin
         mem[waddr] <= wdata;
      end
   end

   // Registered read port, cleared so the output is known after reset
   always_ff @(posedge rclk or negedge rrstn) begin
      if (!rrstn) begin
         rdata <= '0;
      end else if (ren) begin
         rdata <= mem[raddr];  // Oldest word
      end
   end

endmodule

// File: logic/afifo_wptr_full.sv
`timescale 1ns/1ps

module afifo_wptr_full import afifo_pkg::*; (
   input  logic   wclk,
   input  logic   wrstn,
   input  logic   winc,
   input  ptr_t   rgray,
   output logic   wen,
   output addr_t  waddr,
   output ptr_t   wgray,
   output logic   wfull,
   output logic   almost_full,
   output level_t wlevel
);

   // Local pointer state
   ptr_t   wbin;
   ptr_t   wbin_next;
   ptr_t   wgray_next;

   // Read pointer as seen from wclk
   ptr_t   rq1_gray;
   ptr_t   rq2_gray;
   ptr_t   rbin_sync;

   level_t wlevel_next;
   logic   wfull_next;
   logic   almost_full_next;

   // Ignore writes while full
   assign wen   = winc & ~wfull;
   assign waddr = wbin[addr_width-1:0];

   // Two flop synchronizer on the read Gray pointer
   always_ff @(posedge wclk or negedge wrstn) begin
      if (!wrstn) begin
         rq1_gray <= '0;
         rq2_gray <= '0;
      end else begin
         rq1_gray <= rgray;
         rq2_gray <= rq1_gray;
      end
   end

   always_comb begin
      wbin_next  = wbin + ptr_t'(wen);
      wgray_next = bin2gray(wbin_next);
      rbin_sync  = gray2bin(rq2_gray);

      // Stale read pointer keeps the level on the high side
      wlevel_next = level_t'(wbin_next - rbin_sync);

      // Wrap bits differ, address bits match
      wfull_next = (wgray_next == gray_full(rq2_gray));

      almost_full_next = (wlevel_next >= level_t'(af_thresh));
   end

   // Binary and Gray pointers move together
   always_ff @(posedge wclk or negedge wrstn) begin
      if (!wrstn) begin
         wbin  <= '0;
         wgray <= '0;
      end else begin
         wbin  <= wbin_next;
         wgray <= wgray_next;
      end
   end

   // Registered flags and level
   always_ff @(posedge wclk or negedge wrstn) begin
      if (!wrstn) begin
         wfull       <= 1'b0;
         almost_full <= 1'b0;
         wlevel      <= '0;
      end else begin
         wfull       <= wfull_next;
         almost_full <= almost_full_next;
         wlevel      <= wlevel_next;
      end
   end

endmodule

// File: logic/afifo_rptr_empty.sv
`timescale 1ns/1ps

module afifo_rptr_empty import afifo_pkg::*; (
   input  logic   rclk,
   input  logic   rrstn,
   input  logic   rinc,
   input  ptr_t   wgray,
   output logic   ren,
   output addr_t  raddr,
   output ptr_t   rgray,
   output logic   rempty,
   output logic   almost_empty,
   output level_t rlevel
);

   // Local pointer state
   ptr_t   rbin;
   ptr_t   rbin_next;
   ptr_t   rgray_next;

   // Write pointer as seen from rclk
   ptr_t   wq1_gray;
   ptr_t   wq2_gray;
   ptr_t   wbin_sync;

   level_t rlevel_next;
   logic   rempty_next;
   logic   almost_empty_next;

   // Ignore reads while empty
   assign ren   = rinc & ~rempty;
   assign raddr = rbin[addr_width-1:0];

   // Two flop synchronizer on the write Gray pointer
   always_ff @(posedge rclk or negedge rrstn) begin
      if (!rrstn) begin
         wq1_gray <= '0;
         wq2_gray <= '0;
      end else begin
         wq1_gray <= wgray;
         wq2_gray <= wq1_gray;
      end
   end

   always_comb begin
      rbin_next  = rbin + ptr_t'(ren);
      rgray_next = bin2gray(rbin_next);
      wbin_sync  = gray2bin(wq2_gray);

      // Stale write pointer keeps the level on the low side
      rlevel_next = level_t'(wbin_sync - rbin_next);

      // Empty when both Gray pointers are identical
      rempty_next = (rgray_next == wq2_gray);

      almost_empty_next = (rlevel_next <= level_t'(ae_thresh));
   end

   // Binary and Gray pointers move together
   always_ff @(posedge rclk or negedge rrstn) begin
      if (!rrstn) begin
         rbin  <= '0;
         rgray <= '0;
      end else begin
         rbin  <= rbin_next;
         rgray <= rgray_next;
      end
   end

   // Registered flags and level, empty out of reset
   always_ff @(posedge rclk or negedge rrstn) begin
      if (!rrstn) begin
         rempty       <= 1'b1;
         almost_empty <= 1'b1;
         rlevel       <= '0;
      end else begin
         rempty       <= rempty_next;
         almost_empty <= almost_empty_next;
         rlevel       <= rlevel_next;
      end
   end

endmodule

// File: logic/afifo_top.sv
`timescale 1ns/1ps

module afifo_top import afifo_pkg::*; (
   // Write domain
   input  logic   wclk,
   input  logic   wrstn,
   input  logic   winc,
   input  data_t  wdata,

   // Read domain
   input  logic   rclk,
   input  logic   rrstn,
   input  logic   rinc,
   output data_t  rdata,

   // Status
   output logic   wfull,
   output logic   rempty,
   output logic   almost_full,
   output logic   almost_empty,
   output level_t wlevel,
   output level_t rlevel
);

   // RAM control
   logic  wen;
   logic  ren;
   addr_t waddr;
   addr_t raddr;

   // Gray pointers crossing between domains
   ptr_t  wgray;
   ptr_t  rgray;

   afifo_wptr_full i_wptr_full (
      .wclk        (wclk),
      .wrstn       (wrstn),
      .winc        (winc),
      .rgray       (rgray),
      .wen         (wen),
      .waddr       (waddr),
      .wgray       (wgray),
      .wfull       (wfull),
      .almost_full (almost_full),
      .wlevel      (wlevel)
   );

   afifo_rptr_empty i_rptr_empty (
      .rclk         (rclk),
      .rrstn        (rrstn),
      .rinc         (rinc),
      .wgray        (wgray),
      .ren          (ren),
      .raddr        (raddr),
      .rgray        (rgray),
      .rempty       (rempty),
      .almost_empty (almost_empty),
      .rlevel       (rlevel)
   );

   afifo_ram i_ram (
      .wclk  (wclk),
      .wen   (wen),
      .waddr (waddr),
      .wdata (wdata),  // Straight from the port
      .rclk  (rclk),
      .rrstn (rrstn),
      .ren   (ren),
      .raddr (raddr),
      .rdata (rdata)
   );

endmodule

// File: dv/afifo_chk.sv
`timescale 1ns/1ps

module afifo_chk import afifo_pkg::*; (
   input logic   wclk,
   input logic   wrstn,
   input logic   rclk,
   input logic   rrstn,
   input ptr_t   wgray,
   input ptr_t   rgray,
   input logic   wfull,
   input logic   rempty,
   input level_t wlevel
);

   int unsigned fail_count = 0;  // Failed assertions so far

   // A FIFO of 16 cannot look full and empty at once
   no_full_and_empty: assert property (
      @(posedge rclk) disable iff (!rrstn || !wrstn) !(wfull && rempty)
   ) else begin
      fail_count++;
      $error("wfull and rempty are high together");
   end

   // Gray pointers move by one bit per edge
   wgray_one_bit: assert property (
      @(posedge wclk) disable iff (!wrstn) $countones(wgray ^ $past(wgray)) <= 1
   ) else begin
      fail_count++;
      $error("wgray changed more than one bit");
   end

   rgray_one_bit: assert property (
      @(posedge rclk) disable iff (!rrstn) $countones(rgray ^ $past(rgray)) <= 1
   ) else begin
      fail_count++;
      $error("rgray changed more than one bit");
   end

   wlevel_in_range: assert property (
      @(posedge wclk) disable iff (!wrstn) wlevel <= level_t'(fifo_depth)
   ) else begin
      fail_count++;
      $error("wlevel above the FIFO depth");
   end

endmodule

bind afifo_top afifo_chk i_afifo_chk (
   .wclk   (wclk),
   .wrstn  (wrstn),
   .rclk   (rclk),
   .rrstn  (rrstn),
   .wgray  (wgray),
   .rgray  (rgray),
   .wfull  (wfull),
   .rempty (rempty),
   .wlevel (wlevel)
);

// File: dv/afifo_tb.sv
`timescale 1ns/1ps

module afifo_tb import afifo_pkg::*; ();

   localparam int rclk_half    = 50;
   localparam int wclk_half    = 35;  // Drifts against rclk
   localparam int rclk_period  = 2 * rclk_half;
   localparam int drive_delay  = 5;
   localparam int reset_cycles = 10;
   localparam int phase_cycles = 600;
   localparam int num_phases   = 3;
   localparam int drain_cycles = 200;
   localparam int drain_limit  = 2 * fifo_depth + 4;  // Enough to empty a full FIFO
   localparam int timeout_ns   =
      (reset_cycles + num_phases * phase_cycles + drain_cycles) * rclk_period;

   logic   wclk = 1'b0;
   logic   rclk = 1'b0;
   logic   wrstn;
   logic   rrstn;
   logic   winc;
   logic   rinc;
   data_t  wdata;
   data_t  rdata;
   logic   wfull;
   logic   rempty;
   logic   almost_full;
   logic   almost_empty;
   level_t wlevel;
   level_t rlevel;

   // Reference model and stimulus state
   data_t       model_q[$];
   logic [31:0] rng_state = 32'd65256;
   int unsigned wprob = 0;
   int unsigned rprob = 0;
   logic        run_en = 1'b0;
   logic        w_acc;
   data_t       w_word;
   logic        r_acc;

   afifo_top i_afifo_top (
      .wclk         (wclk),
      .wrstn        (wrstn),
      .winc         (winc),
      .wdata        (wdata),
      .rclk         (rclk),
      .rrstn        (rrstn),
      .rinc         (rinc),
      .rdata        (rdata),
      .wfull        (wfull),
      .rempty       (rempty),
      .almost_full  (almost_full),
      .almost_empty (almost_empty),
      .wlevel       (wlevel),
      .rlevel       (rlevel)
   );

   always #(wclk_half) wclk = ~wclk;
   always #(rclk_half) rclk = ~rclk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Shared generator, callers never run in the same time step
   function automatic int unsigned roll_below(input int unsigned range);
      rng_state = xorshift(rng_state);
      return rng_state % range;
   endfunction

   task automatic stop_with_failure();
      $display("TB FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_data(input string what, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("error at %0d ns: %s is %02h, expected %02h", $time, what, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_level(input string what, input level_t got, input int lo, input int hi);
      if (int'(got) < lo || int'(got) > hi) begin
         $display("error at %0d ns: %s is %0d, expected %0d to %0d",
                  $time, what, got, lo, hi);
         stop_with_failure();
      end
   endtask

   initial begin : main
      int waits;
      wrstn = 1'b0;
      rrstn = 1'b0;
      winc  = 1'b0;
      rinc  = 1'b0;
      wdata = '0;
      repeat (reset_cycles) @(posedge rclk);
      #(drive_delay);
      wrstn = 1'b1;
      rrstn = 1'b1;
      @(posedge rclk);
      #(drive_delay);
      check_flag("rempty after reset", rempty, 1'b1);
      check_flag("almost_empty after reset", almost_empty, 1'b1);
      check_flag("wfull after reset", wfull, 1'b0);
      check_flag("almost_full after reset", almost_full, 1'b0);
      check_level("wlevel after reset", wlevel, 0, 0);
      check_level("rlevel after reset", rlevel, 0, 0);
      check_data("rdata after reset", rdata, '0);
      #1;
      for (int p = 0; p < num_phases; p++) begin
         if (p == 0) begin  // Write heavy
            wprob = 70 + roll_below(25);
            rprob = 15 + roll_below(25);
         end else if (p == 1) begin  // Read heavy
            wprob = 15 + roll_below(25);
            rprob = 70 + roll_below(25);
         end else begin
            wprob = 40 + roll_below(20);
            rprob = 40 + roll_below(20);
         end
         $display("phase %0d: write %0d percent, read %0d percent", p, wprob, rprob);
         run_en = 1'b1;
         repeat (phase_cycles) @(posedge rclk);
         #(drive_delay + 1);
      end
      // Drain with reads only
      wprob = 0;
      rprob = 100;
      repeat (4) @(posedge rclk);  // Last pending write reaches the model
      #(drive_delay + 1);
      waits = 0;
      while (model_q.size() != 0 && waits < drain_limit) begin
         @(posedge rclk);
         #(drive_delay + 1);
         waits++;
      end
      check_level("model count after drain", level_t'(model_q.size()), 0, 0);
      waits = 0;
      while (!rempty && waits < 4) begin
         @(posedge rclk);
         #(drive_delay + 1);
         waits++;
      end
      check_flag("rempty after drain", rempty, 1'b1);
      if (i_afifo_top.i_afifo_chk.fail_count != 0) begin
         $display("assertions in afifo_chk failed %0d times",
                  i_afifo_top.i_afifo_chk.fail_count);
         stop_with_failure();
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

   initial begin : write_side
      w_acc  = 1'b0;
      w_word = '0;
      wait (run_en);
      forever begin
         @(posedge wclk);
         #(drive_delay);
         if (w_acc) begin
            model_q.push_back(w_word);
            check_level("model count", level_t'(model_q.size()), 0, fifo_depth);
         end
         if (model_q.size() == fifo_depth) begin
            check_flag("wfull with the FIFO full", wfull, 1'b1);
         end
         check_level("wlevel", wlevel, model_q.size(), fifo_depth);
         check_flag("almost_full", almost_full, wlevel >= level_t'(af_thresh));
         winc   = (roll_below(100) < wprob);
         wdata  = data_t'(roll_below(256));
         w_acc  = winc & ~wfull;  // Writes while full are dropped
         w_word = wdata;
      end
   end

   initial begin : read_side
      data_t exp_word;
      r_acc = 1'b0;
      wait (run_en);
      forever begin
         @(posedge rclk);
         #(drive_delay);
         if (r_acc) begin
            check_flag("model holds a word for the read", model_q.size() != 0, 1'b1);
            exp_word = model_q.pop_front();
            check_data("rdata", rdata, exp_word);
         end
         if (!rempty) begin
            check_flag("model holds data while rempty is low", model_q.size() != 0, 1'b1);
         end
         check_level("rlevel", rlevel, 0, model_q.size());
         check_flag("almost_empty", almost_empty, rlevel <= level_t'(ae_thresh));
         rinc  = (roll_below(100) < rprob);
         r_acc = rinc & ~rempty;
      end
   end

   // Catch bound assertion failures while running
   always @(negedge rclk) begin
      if (i_afifo_top.i_afifo_chk.fail_count != 0) begin
         $display("an assertion in afifo_chk failed at %0d ns", $time);
         stop_with_failure();
      end
   end

   initial begin : watchdog
      #(timeout_ns);
      $display("run timed out after %0d ns before the drain finished", timeout_ns);
      stop_with_failure();
   end

endmodule

// File: build.f
logic/afifo_pkg.sv
logic/afifo_ram.sv
logic/afifo_wptr_full.sv
logic/afifo_rptr_empty.sv
logic/afifo_top.sv
dv/afifo_chk.sv
dv/afifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the async FIFO testbench with Verilator.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --assert -j 0 \
   --top-module afifo_tb \
   -f build.f \
   -o afifo_sim
status=$?
if [ $status -ne 0 ]; then
   echo "compile failed with status $status"
   exit $status
fi

# Raised error limit so assertion failures reach the testbench's own report
./obj_dir/afifo_sim +verilator+error+limit+1000
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

echo "simulation finished with status 0"
exit 0
